/* Makefile */
# Verilator build and run for the link-training testbench

VERILATOR ?= verilator
TOP       ?= link_train_tb
RTL_TOP   ?= link_train_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+tests
source/lt_pkg.sv
source/speed_negotiator.sv
source/os_counter.sv
source/link_train_fsm.sv
source/link_train_top.sv
tests/link_train_tb.sv

/* source/link_train_fsm.sv */
// link-training state machine with step targets, lane select, status flags and the AT request
`timescale 1ns/1ps

module link_train_fsm
  import lt_pkg::*;
#(
  parameter int SENT_CNT_W = CNT_W
)
(
  input  logic                  fsm_clk,
  input  logic                  reset_n,
  input  logic                  lane_disable_i,
  input  logic                  disconnect_sbrx_i,   // far side asks for disconnect
  input  logic                  tdisabled_min_i,
  input  logic                  ttraining_error_timeout_i,
  input  logic                  tgen4_ts1_timeout_i,
  input  logic                  tgen4_ts2_timeout_i,
  input  logic                  new_sym_i,
  input  logic                  t_valid_i,           // AT response received
  input  logic                  trans_error_i,
  input  logic                  trans_sent_i,
  input  logic                  sync_busy_i,
  input  logic                  is_usb4_i,
  input  logic [GEN_W-1:0]      gen_speed_i,
  input  logic                  step_done_i,
  output logic                  probe_o,
  output logic                  capture_o,
  output logic                  clear_o,
  output logic                  count_en_o,
  output logic [OS_W-1:0]       os_code_o,
  output logic [SENT_CNT_W-1:0] sent_target_o,
  output logic [REC_W-1:0]      rec_target_o,
  output logic [OS_W-1:0]       d_sel_o,
  output logic                  fsm_disabled_o,
  output logic                  fsm_training_o,
  output logic                  ts1_gen4_s_o,
  output logic                  ts2_gen4_s_o,
  output logic [TRANS_W-1:0]    trans_sel_o,
  output logic                  disconnect_sbtx_o
);

  logic [STATE_W-1:0] cs;
  logic [STATE_W-1:0] ns;
  logic               in_training;
  logic               at_req_pend;
  logic               at_req_done;

  assign in_training = (cs >= TRAINING_GEN4_TS1) && (cs <= TRAINING_GEN2_3_TS2);

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
      cs <= DISABLED;
    else
      cs <= ns;
  end

  ////////////////////////////////////////
  // next state
  always_comb
  begin
    ns = cs;
    case (cs)
      DISABLED:
        if (tdisabled_min_i)
          ns = CLD_CABLE_PROP;  // minimum disabled time passed
      CLD_CABLE_PROP:
        if (is_usb4_i)
          ns = CLD_DET_DEVICE;
      CLD_DET_DEVICE:
        if (!disconnect_sbrx_i)
          ns = CLD_PARAMETERS_1;
      CLD_PARAMETERS_1:
        if (t_valid_i && !trans_error_i)
          ns = CLD_PARAMETERS_2;
      CLD_PARAMETERS_2:
        if (trans_sent_i)
          ns = CLD_CLK_SWITCH;
      CLD_CLK_SWITCH:
        if (new_sym_i)
          ns = (gen_speed_i == GEN4) ? TRAINING_GEN4_TS1 : TRAINING_GEN2_3_SLOS1;
      TRAINING_GEN4_TS1:
        if (tgen4_ts1_timeout_i)
          ns = CLD_PARAMETERS_1;
        else if (step_done_i)
          ns = TRAINING_GEN4_TS2;
      TRAINING_GEN4_TS2:
        if (tgen4_ts2_timeout_i)
          ns = CLD_PARAMETERS_1;
        else if (step_done_i)
          ns = TRAINING_GEN4_TS3;
      TRAINING_GEN4_TS3:
        if (step_done_i)
          ns = TRAINING_GEN4_TS4;
      TRAINING_GEN4_TS4:
        if (step_done_i && new_sym_i)
          ns = CL0;
      TRAINING_GEN2_3_SLOS1:
        if (step_done_i)
          ns = TRAINING_GEN2_3_SLOS2;
      TRAINING_GEN2_3_SLOS2:
        if (step_done_i)
          ns = TRAINING_GEN2_3_TS1;
      TRAINING_GEN2_3_TS1:
        if (step_done_i)
          ns = TRAINING_GEN2_3_TS2;
      TRAINING_GEN2_3_TS2:
        if (step_done_i && new_sym_i)
          ns = CL0;
      CL0:
        ns = CL0;
      default:
        ns = DISABLED;
    endcase

    // faults, lowest priority first
    if (in_training && ttraining_error_timeout_i)
      ns = CLD_PARAMETERS_1;
    if (cs >= CLD_PARAMETERS_1 && disconnect_sbrx_i)
      ns = CLD_DET_DEVICE;
    if (lane_disable_i)
      ns = DISABLED;
  end

  ////////////////////////////////////////
  // step targets
  always_comb
  begin
    os_code_o     = OS_ZEROS;
    sent_target_o = '0;
    rec_target_o  = REC_G23;
    case (cs)
      TRAINING_GEN4_TS1,
      TRAINING_GEN4_TS2,
      TRAINING_GEN4_TS3,
      TRAINING_GEN4_TS4:
      begin
        os_code_o     = OS_TS1_G4 + OS_W'(cs - TRAINING_GEN4_TS1);  // TS1..TS4 in order
        sent_target_o = SENT_CNT_W'(SENT_G4);
        rec_target_o  = REC_G4;
      end
      TRAINING_GEN2_3_SLOS1,
      TRAINING_GEN2_3_SLOS2:
      begin
        os_code_o     = (cs == TRAINING_GEN2_3_SLOS1) ? OS_SLOS1 : OS_SLOS2;
        sent_target_o = SENT_CNT_W'(SENT_SLOS);
      end
      TRAINING_GEN2_3_TS1:
      begin
        os_code_o     = OS_TS1_G3;
        sent_target_o = (gen_speed_i == GEN2) ? SENT_CNT_W'(SENT_TS1_G2) :
                                                SENT_CNT_W'(SENT_TS1_G3);
      end
      TRAINING_GEN2_3_TS2:
      begin
        os_code_o     = OS_TS2_G3;
        sent_target_o = (gen_speed_i == GEN2) ? SENT_CNT_W'(SENT_TS2_G2) :
                                                SENT_CNT_W'(SENT_TS2_G3);
      end
      default:
        os_code_o = OS_ZEROS;
    endcase
  end

  assign probe_o    = (cs == CLD_CABLE_PROP);
  assign capture_o  = (cs == CLD_PARAMETERS_1);
  assign clear_o    = (cs == DISABLED);
  assign count_en_o = in_training && (ns == cs);  // counters restart on every step change

  ////////////////////////////////////////
  // lane select and status
  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      d_sel_o        <= OS_ZEROS;
      fsm_disabled_o <= 1'b1;
      fsm_training_o <= 1'b0;
      ts1_gen4_s_o   <= 1'b0;
      ts2_gen4_s_o   <= 1'b0;
    end
    else
    begin
      fsm_disabled_o <= (cs == DISABLED);
      fsm_training_o <= in_training;
      ts1_gen4_s_o   <= (cs == TRAINING_GEN4_TS1);
      ts2_gen4_s_o   <= (cs == TRAINING_GEN4_TS2);
      if (cs == CL0 || (in_training && ns == CL0))
        d_sel_o <= OS_DATA;
      else if (in_training)
        d_sel_o <= os_code_o;  // sets go back to back
      else
        d_sel_o <= OS_ZEROS;
    end
  end

  ////////////////////////////////////////
  // AT parameter request
  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      at_req_pend       <= 1'b0;
      at_req_done       <= 1'b0;
      trans_sel_o       <= '0;
      disconnect_sbtx_o <= 1'b1;
    end
    else
    begin
      at_req_pend <= (cs == CLD_PARAMETERS_1);
      if (cs != CLD_PARAMETERS_1)
        at_req_done <= 1'b0;
      else if (trans_sel_o == TRANS_AT_REQ)
        at_req_done <= 1'b1;  // request taken by the sideband

      if (cs == DISABLED || cs == CLD_CABLE_PROP)
      begin
        disconnect_sbtx_o <= 1'b1;  // zeros on sbtx
        trans_sel_o       <= '0;
      end
      else
      begin
        disconnect_sbtx_o <= 1'b0;
        if ((at_req_pend && !at_req_done) || (capture_o && trans_error_i))
        begin
          if (!sync_busy_i)
            trans_sel_o <= TRANS_AT_REQ;
        end
        else
          trans_sel_o <= '0;
      end
    end
  end

endmodule

/* source/link_train_top.sv */
// lane adapter link-training top level; sets the parameters and joins negotiation, counting and FSM
`timescale 1ns/1ps

module link_train_top
  import lt_pkg::*;
#(
  parameter logic [7:0] CABLE_PROP_ADDR = 8'd18,
  parameter int         SENT_CNT_W      = CNT_W
)
(
  input  logic               fsm_clk,
  input  logic               reset_n,
  input  logic               lane_disable_i,
  input  logic               disconnect_sbrx_i,
  input  logic               tdisabled_min_i,
  input  logic               ttraining_error_timeout_i,
  input  logic               tgen4_ts1_timeout_i,
  input  logic               tgen4_ts2_timeout_i,
  input  logic               new_sym_i,
  input  logic               t_valid_i,
  input  logic               trans_error_i,
  input  logic               trans_sent_i,
  input  logic               sync_busy_i,
  input  logic               os_sent_i,
  input  logic [OS_W-1:0]    os_in_l0_i,
  input  logic [OS_W-1:0]    os_in_l1_i,
  input  logic [23:0]        payload_i,
  input  logic [31:0]        c_data_i,
  output logic [TRANS_W-1:0] trans_sel_o,
  output logic               disconnect_sbtx_o,
  output logic               fsm_disabled_o,
  output logic               fsm_training_o,
  output logic               ts1_gen4_s_o,
  output logic               ts2_gen4_s_o,
  output logic [OS_W-1:0]    d_sel_o,
  output logic [GEN_W-1:0]   gen_speed_o,
  output logic [7:0]         c_address_o,
  output logic               c_read_o
);

  logic                  probe;
  logic                  capture;
  logic                  clear;
  logic                  count_en;
  logic                  is_usb4;
  logic                  step_done;
  logic [OS_W-1:0]       os_code;
  logic [SENT_CNT_W-1:0] sent_target;
  logic [REC_W-1:0]      rec_target;

  speed_negotiator #(
    .CABLE_PROP_ADDR (CABLE_PROP_ADDR)
  ) i_speed_negotiator (
    .fsm_clk     (fsm_clk),
    .reset_n     (reset_n),
    .probe_i     (probe),
    .capture_i   (capture),
    .clear_i     (clear),
    .c_data_i    (c_data_i),
    .payload_i   (payload_i),
    .c_address_o (c_address_o),
    .c_read_o    (c_read_o),
    .is_usb4_o   (is_usb4),
    .gen_speed_o (gen_speed_o)
  );

  os_counter #(
    .SENT_CNT_W (SENT_CNT_W)
  ) i_os_counter (
    .fsm_clk       (fsm_clk),
    .reset_n       (reset_n),
    .count_en_i    (count_en),
    .os_code_i     (os_code),
    .sent_target_i (sent_target),
    .rec_target_i  (rec_target),
    .os_sent_i     (os_sent_i),
    .os_in_l0_i    (os_in_l0_i),
    .os_in_l1_i    (os_in_l1_i),
    .step_done_o   (step_done)
  );

  link_train_fsm #(
    .SENT_CNT_W (SENT_CNT_W)
  ) i_link_train_fsm (
    .fsm_clk                   (fsm_clk),
    .reset_n                   (reset_n),
    .lane_disable_i            (lane_disable_i),
    .disconnect_sbrx_i         (disconnect_sbrx_i),
    .tdisabled_min_i           (tdisabled_min_i),
    .ttraining_error_timeout_i (ttraining_error_timeout_i),
    .tgen4_ts1_timeout_i       (tgen4_ts1_timeout_i),
    .tgen4_ts2_timeout_i       (tgen4_ts2_timeout_i),
    .new_sym_i                 (new_sym_i),
    .t_valid_i                 (t_valid_i),
    .trans_error_i             (trans_error_i),
    .trans_sent_i              (trans_sent_i),
    .sync_busy_i               (sync_busy_i),
    .is_usb4_i                 (is_usb4),
    .gen_speed_i               (gen_speed_o),
    .step_done_i               (step_done),
    .probe_o                   (probe),
    .capture_o                 (capture),
    .clear_o                   (clear),
    .count_en_o                (count_en),
    .os_code_o                 (os_code),
    .sent_target_o             (sent_target),
    .rec_target_o              (rec_target),
    .d_sel_o                   (d_sel_o),
    .fsm_disabled_o            (fsm_disabled_o),
    .fsm_training_o            (fsm_training_o),
    .ts1_gen4_s_o              (ts1_gen4_s_o),
    .ts2_gen4_s_o              (ts2_gen4_s_o),
    .trans_sel_o               (trans_sel_o),
    .disconnect_sbtx_o         (disconnect_sbtx_o)
  );

endmodule

/* source/lt_pkg.sv */
// shared codes, widths and count targets for the lane link-training control; import where needed
package lt_pkg;

  ////////////////////////////////////////
  // generations
  localparam int GEN_W = 2;
  localparam logic [GEN_W-1:0] GEN4 = 2'd0;
  localparam logic [GEN_W-1:0] GEN3 = 2'd1;
  localparam logic [GEN_W-1:0] GEN2 = 2'd2;

  ////////////////////////////////////////
  // link-training states
  localparam int STATE_W = 4;
  localparam logic [STATE_W-1:0] DISABLED              = 4'd0;
  localparam logic [STATE_W-1:0] CLD_CABLE_PROP        = 4'd1;
  localparam logic [STATE_W-1:0] CLD_DET_DEVICE        = 4'd2;
  localparam logic [STATE_W-1:0] CLD_PARAMETERS_1      = 4'd3;  // AT request and response
  localparam logic [STATE_W-1:0] CLD_PARAMETERS_2      = 4'd4;  // waiting for our AT reply to go
  localparam logic [STATE_W-1:0] CLD_CLK_SWITCH        = 4'd5;
  localparam logic [STATE_W-1:0] TRAINING_GEN4_TS1     = 4'd6;
  localparam logic [STATE_W-1:0] TRAINING_GEN4_TS2     = 4'd7;
  localparam logic [STATE_W-1:0] TRAINING_GEN4_TS3     = 4'd8;
  localparam logic [STATE_W-1:0] TRAINING_GEN4_TS4     = 4'd9;
  localparam logic [STATE_W-1:0] TRAINING_GEN2_3_SLOS1 = 4'd10;
  localparam logic [STATE_W-1:0] TRAINING_GEN2_3_SLOS2 = 4'd11;
  localparam logic [STATE_W-1:0] TRAINING_GEN2_3_TS1   = 4'd12;
  localparam logic [STATE_W-1:0] TRAINING_GEN2_3_TS2   = 4'd13;
  localparam logic [STATE_W-1:0] CL0                   = 4'd14;

  ////////////////////////////////////////
  // ordered-set codes on d_sel and the lane inputs
  localparam int OS_W = 4;
  localparam logic [OS_W-1:0] OS_SLOS1  = 4'd0;
  localparam logic [OS_W-1:0] OS_SLOS2  = 4'd1;
  localparam logic [OS_W-1:0] OS_TS1_G3 = 4'd2;
  localparam logic [OS_W-1:0] OS_TS2_G3 = 4'd3;
  localparam logic [OS_W-1:0] OS_TS1_G4 = 4'd4;
  localparam logic [OS_W-1:0] OS_TS2_G4 = 4'd5;
  localparam logic [OS_W-1:0] OS_TS3_G4 = 4'd6;
  localparam logic [OS_W-1:0] OS_TS4_G4 = 4'd7;
  localparam logic [OS_W-1:0] OS_DATA   = 4'd8;  // transport layer data
  localparam logic [OS_W-1:0] OS_ZEROS  = 4'd9;  // idle lanes

  ////////////////////////////////////////
  // per-step count targets
  localparam int CNT_W = 6;
  localparam int REC_W = 2;
  localparam logic [CNT_W-1:0] SENT_G4     = 6'd16;
  localparam logic [CNT_W-1:0] SENT_SLOS   = 6'd2;
  localparam logic [CNT_W-1:0] SENT_TS1_G2 = 6'd32;
  localparam logic [CNT_W-1:0] SENT_TS1_G3 = 6'd16;
  localparam logic [CNT_W-1:0] SENT_TS2_G2 = 6'd16;
  localparam logic [CNT_W-1:0] SENT_TS2_G3 = 6'd8;
  localparam logic [REC_W-1:0] REC_G4      = 2'd1;
  localparam logic [REC_W-1:0] REC_G23     = 2'd2;

  // cable-properties word and AT payload decode
  localparam logic [7:0] USB4_ID = 8'h40;
  localparam int CABLE_G4_BIT   = 21;
  localparam int CABLE_G3_BIT   = 20;
  localparam int PAYLOAD_G4_BIT = 18;
  localparam int PAYLOAD_G3_BIT = 13;

  // sideband transaction select
  localparam int TRANS_W = 3;
  localparam logic [TRANS_W-1:0] TRANS_AT_REQ = 3'd2;

endpackage

/* source/os_counter.sv */
// counts sent and received ordered sets of one training step and flags when its targets are met
`timescale 1ns/1ps

module os_counter
  import lt_pkg::*;
#(
  parameter int SENT_CNT_W = CNT_W
)
(
  input  logic                  fsm_clk,
  input  logic                  reset_n,
  input  logic                  count_en_i,     // low clears all counters
  input  logic [OS_W-1:0]       os_code_i,      // set expected in this step
  input  logic [SENT_CNT_W-1:0] sent_target_i,
  input  logic [REC_W-1:0]      rec_target_i,
  input  logic                  os_sent_i,      // one pulse per set sent
  input  logic [OS_W-1:0]       os_in_l0_i,
  input  logic [OS_W-1:0]       os_in_l1_i,
  output logic                  step_done_o
);

  logic [SENT_CNT_W-1:0]   sent_cnt;
  logic [1:0][OS_W-1:0]    lane_code;
  logic [1:0]              lane_done;

  assign lane_code = {os_in_l1_i, os_in_l0_i};

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
      sent_cnt <= '0;
    else if (!count_en_i)
      sent_cnt <= '0;
    else if (os_sent_i && sent_cnt != sent_target_i)
      sent_cnt <= sent_cnt + 1'b1;  // saturates at target
  end

  ////////////////////////////////////////
  // one receive counter per lane
  for (genvar l = 0; l < 2; l++)
  begin : g_lane
    logic [REC_W-1:0] rec_cnt;

    always_ff @(posedge fsm_clk or negedge reset_n)
    begin
      if (!reset_n)
        rec_cnt <= '0;
      else if (!count_en_i)
        rec_cnt <= '0;
      else if (lane_code[l] == os_code_i && rec_cnt != rec_target_i)
        rec_cnt <= rec_cnt + 1'b1;
    end

    assign lane_done[l] = (rec_cnt == rec_target_i);
  end

  assign step_done_o = (sent_cnt == sent_target_i) && (&lane_done);

endmodule

/* source/speed_negotiator.sv */
// reads the cable properties once per probe and resolves the link generation with the far adapter
`timescale 1ns/1ps

module speed_negotiator
  import lt_pkg::*;
#(
  parameter logic [7:0] CABLE_PROP_ADDR = 8'd18
)
(
  input  logic             fsm_clk,
  input  logic             reset_n,
  input  logic             probe_i,      // high while probing the cable
  input  logic             capture_i,    // high during the parameter exchange
  input  logic             clear_i,      // high while disabled
  input  logic [31:0]      c_data_i,
  input  logic [23:0]      payload_i,    // AT response payload
  output logic [7:0]       c_address_o,
  output logic             c_read_o,
  output logic             is_usb4_o,
  output logic [GEN_W-1:0] gen_speed_o
);

  logic             probe_q;
  logic             capture_q;
  logic [GEN_W-1:0] cable_gen;
  logic [GEN_W-1:0] far_gen;
  logic [GEN_W-1:0] lowest_gen;

  ////////////////////////////////////////
  // configuration space read
  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      probe_q     <= 1'b0;
      c_read_o    <= 1'b0;
      c_address_o <= 8'h00;
    end
    else
    begin
      probe_q     <= probe_i;
      c_read_o    <= probe_i && !probe_q;  // one read per probe
      c_address_o <= probe_i ? CABLE_PROP_ADDR : 8'h00;
    end
  end

  ////////////////////////////////////////
  // cable and far adapter generations
  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      is_usb4_o <= 1'b0;
      cable_gen <= GEN4;
      far_gen   <= GEN4;
      capture_q <= 1'b0;
    end
    else
    begin
      capture_q <= capture_i;
      if (clear_i)
      begin
        is_usb4_o <= 1'b0;
        cable_gen <= GEN4;
        far_gen   <= GEN4;
      end
      else
      begin
        if (probe_i)
        begin
          is_usb4_o <= (c_data_i[7:0] == USB4_ID);
          cable_gen <= c_data_i[CABLE_G4_BIT] ? GEN4 :
                       c_data_i[CABLE_G3_BIT] ? GEN3 : GEN2;
        end
        if (capture_i)
          far_gen <= payload_i[PAYLOAD_G4_BIT] ? GEN4 :
                     payload_i[PAYLOAD_G3_BIT] ? GEN3 : GEN2;
      end
    end
  end

  // the slower side sets the pace
  always_comb
  begin
    if (cable_gen == GEN2 || far_gen == GEN2)
      lowest_gen = GEN2;
    else if (cable_gen == GEN3 || far_gen == GEN3)
      lowest_gen = GEN3;
    else
      lowest_gen = GEN4;
  end

  always_ff @(posedge fsm_clk or negedge reset_n)
  begin
    if (!reset_n)
      gen_speed_o <= GEN4;
    else if (clear_i || probe_i)
      gen_speed_o <= GEN4;
    else if (capture_q)
      gen_speed_o <= lowest_gen;  // trails the last capture by one cycle
  end

endmodule

/* tests/lt_tb_tasks.svh */
// stimulus tasks for the link-training testbench; included inside the testbench module
`ifndef LT_TB_TASKS_SVH
`define LT_TB_TASKS_SVH

  ////////////////////////////////////////
  // cable probe and AT exchange
  task automatic probe_cable(input logic [31:0] word, input int cycles);
    c_data_i = word;
    tdisabled_min_i = 1'b1;
    read_cnt = 0;
    repeat (cycles)
    begin
      tick();
      if (c_read_o)
        read_cnt++;
    end
  endtask

  task automatic finish_probe(input logic [31:0] word);
    int n;
    n = 0;
    c_data_i = word;
    while (disconnect_sbtx_o !== 1'b0 && n < WAIT_MAX)
    begin
      tick();
      n++;
    end
    if (disconnect_sbtx_o !== 1'b0)
    begin
      err_cnt++;
      $display("disconnect_sbtx_o stayed high after a USB4 cable word");
    end
    tdisabled_min_i = 1'b0;
  endtask

  task automatic at_exchange();
    t_valid_i = 1'b1;                  // response without error
    tick();
    t_valid_i = 1'b0;
    tick();
    trans_sent_i = 1'b1;
    tick();
    trans_sent_i = 1'b0;
  endtask

  task automatic pulse_new_sym();
    new_sym_i = 1'b1;
    tick();
    new_sym_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // ordered-set streams
  task automatic drive_lanes(input logic [OS_W-1:0] code, input int n);
    os_in_l0_i = code;
    os_in_l1_i = code;
    repeat (n) tick();
    os_in_l0_i = OS_ZEROS;
    os_in_l1_i = OS_ZEROS;
  endtask

  task automatic send_sets(input int n);
    int gap;
    repeat (n)
    begin
      os_sent_i = 1'b1;
      tick();
      os_sent_i = 1'b0;
      gap = $unsigned($random(seed)) % 3;  // idle cycles between sets
      repeat (gap) tick();
    end
  endtask

  task automatic run_step(input logic [OS_W-1:0] code, input int sent, input int rec,
                          input logic last, input logic [OS_W-1:0] next_code);
    check_eq("d_sel_o at step start", d_sel_o, code);
    check_eq("fsm_training_o", fsm_training_o, 1);
    check_eq("ts1_gen4_s_o", ts1_gen4_s_o, code == OS_TS1_G4);
    check_eq("ts2_gen4_s_o", ts2_gen4_s_o, code == OS_TS2_G4);
    drive_lanes(code, rec);
    send_sets(sent - 1);
    repeat (3) tick();
    check_eq("d_sel_o one set short", d_sel_o, code);
    send_sets(1);
    if (last)
      pulse_new_sym();
    wait_d_sel(next_code);
  endtask

`endif

/* tests/link_train_tb.sv */
// testbench for the lane link-training top level; runs the bring-up, training and fault sequences
`timescale 1ns/1ps

module link_train_tb
  import lt_pkg::*;
;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int WAIT_MAX    = 100;
  // worst case of one training step with lanes, 32 sets with gaps, early-advance check and wait
  localparam int STEP_MAX    = 3 + 32 * 3 + 3 + WAIT_MAX;
  // seven tests with their fixed cycles, nine open waits and eight training steps
  localparam int TEST_MAX    = 70 + 9 * WAIT_MAX + 8 * STEP_MAX;
  localparam int RUN_LIMIT   = 2 * TEST_MAX;

  logic               fsm_clk;
  logic               reset_n;
  logic               lane_disable_i;
  logic               disconnect_sbrx_i;
  logic               tdisabled_min_i;
  logic               ttraining_error_timeout_i;
  logic               tgen4_ts1_timeout_i;
  logic               tgen4_ts2_timeout_i;
  logic               new_sym_i;
  logic               t_valid_i;
  logic               trans_error_i;
  logic               trans_sent_i;
  logic               sync_busy_i;
  logic               os_sent_i;
  logic [OS_W-1:0]    os_in_l0_i;
  logic [OS_W-1:0]    os_in_l1_i;
  logic [23:0]        payload_i;
  logic [31:0]        c_data_i;
  logic [TRANS_W-1:0] trans_sel_o;
  logic               disconnect_sbtx_o;
  logic               fsm_disabled_o;
  logic               fsm_training_o;
  logic               ts1_gen4_s_o;
  logic               ts2_gen4_s_o;
  logic [OS_W-1:0]    d_sel_o;
  logic [GEN_W-1:0]   gen_speed_o;
  logic [7:0]         c_address_o;
  logic               c_read_o;

  int seed = 90969;
  int err_cnt = 0;
  int test_no = 0;
  int test_err_start = 0;
  int cycle_cnt = 0;
  int read_cnt;

  link_train_top #(
    .CABLE_PROP_ADDR (8'd18),
    .SENT_CNT_W      (CNT_W)
  ) i_dut (.*);

  initial fsm_clk = 1'b0;
  always #(CLK_PERIOD / 2) fsm_clk = ~fsm_clk;

  always @(posedge fsm_clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= RUN_LIMIT)
    begin
      $display("run stopped after %0d cycles without finishing", cycle_cnt);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // invariants over the whole run
  a_read_addr: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    c_read_o |-> c_address_o == 8'd18)
  else
  begin
    err_cnt++;
    $display("ERR @%0t: c_read_o high with wrong address", $time);
  end
  a_ts1_step: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    ts1_gen4_s_o |-> d_sel_o == OS_TS1_G4)
  else
  begin
    err_cnt++;
    $display("ERR @%0t: ts1 flag outside TS1 step", $time);
  end
  a_ts2_step: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    ts2_gen4_s_o |-> d_sel_o == OS_TS2_G4)
  else
  begin
    err_cnt++;
    $display("ERR @%0t: ts2 flag outside TS2 step", $time);
  end
  a_disabled_idle: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    fsm_disabled_o |-> (d_sel_o == OS_ZEROS && !fsm_training_o))
  else
  begin
    err_cnt++;
    $display("ERR @%0t: lanes active while disabled", $time);
  end
  a_req_not_busy: assert property (@(posedge fsm_clk) disable iff (!reset_n)
    (trans_sel_o == TRANS_AT_REQ && $past(trans_sel_o) != TRANS_AT_REQ) |-> !$past(sync_busy_i))
  else
  begin
    err_cnt++;
    $display("ERR @%0t: AT request raised while busy", $time);
  end

  task automatic tick();
    @(posedge fsm_clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_eq(input string what, input int got, input int exp);
    assert (got == exp)
    else
    begin
      err_cnt++;
      $display("ERR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic wait_d_sel(input logic [OS_W-1:0] val);
    int n;
    n = 0;
    while (d_sel_o !== val && n < WAIT_MAX)
    begin
      tick();
      n++;
    end
    if (d_sel_o !== val)
    begin
      err_cnt++;
      $display("d_sel_o never reached %0d within %0d cycles", val, WAIT_MAX);
    end
  endtask

  task automatic wait_trans_sel(input logic [TRANS_W-1:0] val);
    int n;
    n = 0;
    while (trans_sel_o !== val && n < WAIT_MAX)
    begin
      tick();
      n++;
    end
    if (trans_sel_o !== val)
    begin
      err_cnt++;
      $display("trans_sel_o never reached %0d within %0d cycles", val, WAIT_MAX);
    end
  endtask

  task automatic start_test();
    test_no++;
    test_err_start = err_cnt;
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s %s", test_no, name,
             (err_cnt == test_err_start) ? "passed" : "failed");
  endtask

  `include "lt_tb_tasks.svh"

  ////////////////////////////////////////
  // stimulus
  initial
  begin
    reset_n = 1'b0;
    lane_disable_i = 1'b0;
    disconnect_sbrx_i = 1'b0;
    tdisabled_min_i = 1'b0;
    ttraining_error_timeout_i = 1'b0;
    tgen4_ts1_timeout_i = 1'b0;
    tgen4_ts2_timeout_i = 1'b0;
    new_sym_i = 1'b0;
    t_valid_i = 1'b0;
    trans_error_i = 1'b0;
    trans_sent_i = 1'b0;
    sync_busy_i = 1'b1;                // sideband busy at first
    os_sent_i = 1'b0;
    os_in_l0_i = OS_ZEROS;
    os_in_l1_i = OS_ZEROS;
    payload_i = 24'h04_0000;           // far adapter GEN4
    c_data_i = 32'h0;
    repeat (2) @(posedge fsm_clk);
    #DRIVE_DELAY;
    reset_n = 1'b1;

    start_test();
    repeat (4) tick();
    check_eq("fsm_disabled_o", fsm_disabled_o, 1);
    check_eq("fsm_training_o", fsm_training_o, 0);
    check_eq("ts flags", {ts1_gen4_s_o, ts2_gen4_s_o}, 0);
    check_eq("d_sel_o", d_sel_o, OS_ZEROS);
    check_eq("trans_sel_o", trans_sel_o, 0);
    check_eq("disconnect_sbtx_o", disconnect_sbtx_o, 1);
    check_eq("c_read_o", c_read_o, 0);
    check_eq("gen_speed_o", gen_speed_o, GEN4);
    end_test("reset values");

    start_test();
    probe_cable(32'h0020_0041, 8);     // no USB4 id
    check_eq("c_read_o pulses", read_cnt, 1);
    check_eq("fsm_disabled_o", fsm_disabled_o, 0);
    check_eq("disconnect_sbtx_o while probing", disconnect_sbtx_o, 1);
    finish_probe(32'h0020_0040);
    end_test("cable probe");

    start_test();
    repeat (4) tick();
    check_eq("trans_sel_o while busy", trans_sel_o, 0);
    sync_busy_i = 1'b0;
    wait_trans_sel(TRANS_AT_REQ);
    at_exchange();
    tick();
    check_eq("trans_sel_o after request", trans_sel_o, 0);
    check_eq("gen_speed_o", gen_speed_o, GEN4);
    check_eq("d_sel_o in clock switch", d_sel_o, OS_ZEROS);
    end_test("AT request");

    start_test();
    pulse_new_sym();
    wait_d_sel(OS_TS1_G4);
    run_step(OS_TS1_G4, 16, 1, 1'b0, OS_TS2_G4);
    run_step(OS_TS2_G4, 16, 1, 1'b0, OS_TS3_G4);
    run_step(OS_TS3_G4, 16, 1, 1'b0, OS_TS4_G4);
    run_step(OS_TS4_G4, 16, 1, 1'b1, OS_DATA);
    tick();
    check_eq("fsm_training_o in CL0", fsm_training_o, 0);
    end_test("GEN4 training");

    start_test();
    lane_disable_i = 1'b1;
    tick();
    lane_disable_i = 1'b0;
    tick();
    check_eq("fsm_disabled_o", fsm_disabled_o, 1);
    check_eq("d_sel_o", d_sel_o, OS_ZEROS);
    end_test("lane disable");

    start_test();
    payload_i = 24'h00_2000;           // far adapter GEN3
    probe_cable(32'h0020_0040, 2);
    finish_probe(32'h0020_0040);
    wait_trans_sel(TRANS_AT_REQ);
    at_exchange();
    tick();
    check_eq("gen_speed_o", gen_speed_o, GEN3);
    pulse_new_sym();
    wait_d_sel(OS_SLOS1);
    ttraining_error_timeout_i = 1'b1;
    tick();
    ttraining_error_timeout_i = 1'b0;
    wait_d_sel(OS_ZEROS);
    check_eq("fsm_training_o after timeout", fsm_training_o, 0);
    wait_trans_sel(TRANS_AT_REQ);      // parameters requested again
    end_test("training timeout");

    start_test();
    at_exchange();
    pulse_new_sym();
    wait_d_sel(OS_SLOS1);
    run_step(OS_SLOS1, 2, 2, 1'b0, OS_SLOS2);
    run_step(OS_SLOS2, 2, 2, 1'b0, OS_TS1_G3);
    run_step(OS_TS1_G3, 16, 2, 1'b0, OS_TS2_G3);
    run_step(OS_TS2_G3, 8, 2, 1'b1, OS_DATA);
    tick();
    check_eq("fsm_training_o in CL0", fsm_training_o, 0);
    end_test("GEN3 training");

    $display("tests %0d, errors %0d", test_no, err_cnt);
    if (err_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule
